// File: Bender.yml
package:
  name: dz_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpuPkg.sv
      - hw/cpuIf.sv
      - hw/ucodeDecode.sv
      - hw/uopExecute.sv
      - hw/regResult.sv
      - hw/dzCore.sv
  - target: test
    files:
      - tests/coreChecker.sv
      - tests/tbCore.sv

// File: hw/cpuConsts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// --------------------
// Datapath and microcode sizes
// --------------------
`define DATA_W      8
`define ADDR_W      16
`define UPC_W       6
`define UROM_DEPTH  64

// Microcode word is eof condition, pc increment, command, source and destination
`define UOP_W       15

// --------------------
// Register codes as they appear in the opcode fields
// --------------------
`define REG_B       3'd0
`define REG_C       3'd1
`define REG_D       3'd2
`define REG_E       3'd3
`define REG_H       3'd4
`define REG_L       3'd5
`define REG_MEM     3'd6
`define REG_A       3'd7

// Wider select codes used by the micro-ops
`define SEL_HL      {1'b0, `REG_MEM}
`define SEL_PC      4'd8
`define SEL_X8      4'd9
`define SEL_X16L    4'd10
`define SEL_X16H    4'd11

// ROM-only codes that take the register from the instruction register
`define SEL_IRD     4'd14
`define SEL_IRS     4'd15

`endif

// File: hw/cpuIf.sv
`timescale 1ns/1ps
`default_nettype none

// Micro-op issued by the decode stage
interface uopIf import cpuPkg::*;
();
	uopCmdT cmd;
	regSelT src;
	regSelT dst;
	logic   incPc;
	dataT   opcode;
	logic   valid;

	modport drv (output cmd, src, dst, incPc, opcode, valid);
	modport rcv (input cmd, src, dst, incPc, opcode, valid);
endinterface

// Register file writes forward and register values back
interface regIf import cpuPkg::*;
();
	logic   writeEn;
	regSelT writeSel;
	dataT   writeData;
	logic   flagsWe;
	logic   zeroFlag;
	logic   pcLoad;
	logic   pcInc;
	dataT   rdVal [8];
	addrT   pc;
	addrT   hl;
	dataT   x8;
	addrT   x16;
	logic   flagZ;

	modport drv (
		output writeEn, writeSel, writeData, flagsWe, zeroFlag, pcLoad, pcInc,
		input  rdVal, pc, hl, x8, x16, flagZ
	);
	modport rcv (
		input  writeEn, writeSel, writeData, flagsWe, zeroFlag, pcLoad, pcInc,
		output rdVal, pc, hl, x8, x16, flagZ
	);
endinterface

`default_nettype wire

// File: hw/cpuPkg.sv
`default_nettype none

`include "cpuConsts.svh"

package cpuPkg;

	// --------------------
	// Plain vectors
	// --------------------

	// One data byte as it travels on the memory bus and through the ALU
	typedef logic [`DATA_W-1:0] dataT;

	// Memory address and program counter
	typedef logic [`ADDR_W-1:0] addrT;

	// Microcode ROM index
	typedef logic [`UPC_W-1:0] upcT;

	// Codes 0 to 7 follow the opcode register fields and 6 stands for the byte at HL
	// Codes above 7 reach pc and the temporaries
	typedef logic [3:0] regSelT;

	// --------------------
	// Enumerations
	// --------------------

	// Micro-commands carried by each ROM word
	typedef enum logic [3:0]
	{
		nop,    // No action
		fetch,  // Read the opcode at pc and dispatch to its flow
		sma,    // Stage a memory byte into X8
		srm,    // Set a register from memory
		smw,    // Memory write of a register byte
		aluOp,  // AND or XOR into A with the Z flag
		ldrr,   // Register to register copy
		spc,    // Load pc from X16
		halt    // Park the core
	} uopCmdT;

	// Flow sequencer states
	typedef enum logic [2:0]
	{
		afterReset,
		startFlow,
		runFlow,
		endFlow,
		halted
	} flowStateT;

endpackage

`default_nettype wire

// File: hw/dzCore.sv
`timescale 1ns/1ps
`default_nettype none

module dzCore import cpuPkg::*;
(
	input  logic iClock,
	input  logic rstN,
	output addrT mcuAddr,
	output dataT mcuWrData,
	output logic mcuWe,
	input  dataT mcuRdData,
	output logic halt
);

	// --------------------
	// Stage links
	// --------------------
	uopIf uopBus ();
	regIf regBus ();

	ucodeDecode uDecode
	(
		.iClock    (iClock),
		.rstN      (rstN),
		.mcuRdData (mcuRdData),
		.zeroFlag  (regBus.flagZ),
		.uop       (uopBus),
		.halt      (halt)
	);

	uopExecute uExecute
	(
		.mcuRdData (mcuRdData),
		.mcuAddr   (mcuAddr),
		.mcuWrData (mcuWrData),
		.mcuWe     (mcuWe),
		.uop       (uopBus),
		.regs      (regBus)
	);

	// Register file, flags and pc
	regResult uResult
	(
		.iClock (iClock),
		.rstN   (rstN),
		.regs   (regBus)
	);

endmodule

`default_nettype wire

// File: hw/regResult.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module regResult import cpuPkg::*;
(
	input logic iClock,
	input logic rstN,
	regIf.rcv   regs
);

	// Slot 6 has no register of its own and holds X8 instead
	dataT       gpr [8];
	addrT       x16;
	addrT       pc;
	logic       flagZ;
	logic [9:0] wrHot;

	// --------------------
	// Write select decode
	// --------------------
	always_comb
	begin
		wrHot = '0;
		if (regs.writeEn)
		begin
			case (regs.writeSel)
				{1'b0, `REG_B}: wrHot = 10'b00_0000_0001;
				{1'b0, `REG_C}: wrHot = 10'b00_0000_0010;
				{1'b0, `REG_D}: wrHot = 10'b00_0000_0100;
				{1'b0, `REG_E}: wrHot = 10'b00_0000_1000;
				{1'b0, `REG_H}: wrHot = 10'b00_0001_0000;
				{1'b0, `REG_L}: wrHot = 10'b00_0010_0000;
				`SEL_X8:        wrHot = 10'b00_0100_0000;
				{1'b0, `REG_A}: wrHot = 10'b00_1000_0000;
				`SEL_X16L:      wrHot = 10'b01_0000_0000;
				`SEL_X16H:      wrHot = 10'b10_0000_0000;
				default:        wrHot = '0;
			endcase
		end
	end

	// --------------------
	// Register storage
	// --------------------
	always_ff @(posedge iClock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 8; i++)
				gpr[i] <= '0;
			x16   <= '0;
			pc    <= '0;
			flagZ <= 1'b0;
		end
		else
		begin
			for (int i = 0; i < 8; i++)
			begin
				if (wrHot[i])
					gpr[i] <= regs.writeData;
			end
			if (wrHot[8])
				x16[7:0] <= regs.writeData;
			if (wrHot[9])
				x16[15:8] <= regs.writeData;
			if (regs.flagsWe)
				flagZ <= regs.zeroFlag;
			// A jump wins over the fetch increment
			if (regs.pcLoad)
				pc <= x16;
			else if (regs.pcInc)
				pc <= pc + 1'b1;
		end
	end

	assign regs.rdVal = gpr;
	assign regs.hl    = {gpr[`REG_H], gpr[`REG_L]};
	assign regs.x8    = gpr[`REG_MEM];
	assign regs.x16   = x16;
	assign regs.pc    = pc;
	assign regs.flagZ = flagZ;

endmodule

`default_nettype wire

// File: hw/ucodeDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module ucodeDecode import cpuPkg::*;
(
	input  logic iClock,
	input  logic rstN,
	input  dataT mcuRdData,
	input  logic zeroFlag,
	uopIf.drv    uop,
	output logic halt
);

	// Flow start addresses in the ROM
	localparam upcT flowFetch = 6'd0;
	localparam upcT flowNop   = 6'd1;
	localparam upcT flowLdRN  = 6'd2;
	localparam upcT flowLdHlN = 6'd3;
	localparam upcT flowLdRR  = 6'd5;
	localparam upcT flowLdRHl = 6'd6;
	localparam upcT flowLdHlR = 6'd7;
	localparam upcT flowAluR  = 6'd8;
	localparam upcT flowAluHl = 6'd9;
	localparam upcT flowJp    = 6'd11;
	localparam upcT flowHalt  = 6'd14;

	// End of flow conditions held in the top bits of each word
	localparam logic [1:0] eofNever  = 2'd0;
	localparam logic [1:0] eofAlways = 2'd1;
	localparam logic [1:0] eofIfZ    = 2'd2;
	localparam logic [1:0] eofIfNz   = 2'd3;

	flowStateT         state;
	upcT               upc;
	upcT               upcInc;
	dataT              ir;
	logic [`UOP_W-1:0] word;
	logic [1:0]        wEof;
	logic              wInc;
	uopCmdT            wCmd;
	regSelT            wSrc;
	regSelT            wDst;
	logic              eofHit;

	function automatic logic [`UOP_W-1:0] mkUop(input logic [1:0] eofSel, input logic inc,
		input uopCmdT cmd, input regSelT src, input regSelT dst);
		return {eofSel, inc, cmd, src, dst};
	endfunction

	// Maps a fetched opcode to the start of its flow
	function automatic upcT lookupFlow(input dataT op);
		upcT f;
		f = flowNop;
		if (op == 8'h76)
			f = flowHalt;
		else if (op == 8'hC3)
			f = flowJp;
		else if (op[7:6] == 2'b00 && op[2:0] == `REG_MEM)
			f = (op[5:3] == `REG_MEM) ? flowLdHlN : flowLdRN;
		else if (op[7:6] == 2'b01)
		begin
			if (op[2:0] == `REG_MEM)
				f = flowLdRHl;
			else if (op[5:3] == `REG_MEM)
				f = flowLdHlR;
			else
				f = flowLdRR;
		end
		else if (op[7:4] == 4'b1010)
			f = (op[2:0] == `REG_MEM) ? flowAluHl : flowAluR;
		return f;
	endfunction

	function automatic regSelT resolveSel(input regSelT f, input dataT op);
		case (f)
			`SEL_IRD: return {1'b0, op[5:3]};
			`SEL_IRS: return {1'b0, op[2:0]};
			default:  return f;
		endcase
	endfunction

	// --------------------
	// Microcode ROM
	// --------------------
	always_comb
	begin
		unique case (upc)
			flowFetch:     word = mkUop(eofNever, 1'b1, fetch, `SEL_PC, `SEL_PC);
			flowNop:       word = mkUop(eofAlways, 1'b0, nop, `SEL_PC, `SEL_PC);
			flowLdRN:      word = mkUop(eofAlways, 1'b1, srm, `SEL_PC, `SEL_IRD);
			flowLdHlN:     word = mkUop(eofNever, 1'b1, sma, `SEL_PC, `SEL_X8);
			flowLdHlN + 1: word = mkUop(eofAlways, 1'b0, smw, `SEL_X8, `SEL_IRD);
			flowLdRR:      word = mkUop(eofAlways, 1'b0, ldrr, `SEL_IRS, `SEL_IRD);
			flowLdRHl:     word = mkUop(eofAlways, 1'b0, srm, `SEL_IRS, `SEL_IRD);
			flowLdHlR:     word = mkUop(eofAlways, 1'b0, smw, `SEL_IRS, `SEL_IRD);
			flowAluR:      word = mkUop(eofAlways, 1'b0, aluOp, `SEL_IRS, {1'b0, `REG_A});
			// The byte at HL is staged in X8, which also answers to code 6
			flowAluHl:     word = mkUop(eofNever, 1'b0, sma, `SEL_IRS, `SEL_X8);
			flowAluHl + 1: word = mkUop(eofAlways, 1'b0, aluOp, `SEL_IRS, {1'b0, `REG_A});
			// Jump target arrives low byte first
			flowJp:        word = mkUop(eofNever, 1'b1, srm, `SEL_PC, `SEL_X16L);
			flowJp + 1:    word = mkUop(eofNever, 1'b1, srm, `SEL_PC, `SEL_X16H);
			flowJp + 2:    word = mkUop(eofAlways, 1'b0, spc, `SEL_X16L, `SEL_PC);
			flowHalt:      word = mkUop(eofAlways, 1'b0, cpuPkg::halt, `SEL_PC, `SEL_PC);
			default:       word = mkUop(eofAlways, 1'b0, nop, `SEL_PC, `SEL_PC);
		endcase
	end

	assign wEof = word[14:13];
	assign wInc = word[12];
	assign wCmd = uopCmdT'(word[11:8]);
	assign wSrc = word[7:4];
	assign wDst = word[3:0];

	always_comb
	begin
		unique case (wEof)
			eofNever:  eofHit = 1'b0;
			eofAlways: eofHit = 1'b1;
			eofIfZ:    eofHit = zeroFlag;
			eofIfNz:   eofHit = ~zeroFlag;
		endcase
	end

	// A runaway micro-PC wraps back to the fetch flow
	assign upcInc = upc + 1'b1;

	// --------------------
	// Flow sequencer
	// --------------------
	always_ff @(posedge iClock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= afterReset;
			upc   <= flowFetch;
			ir    <= '0;
		end
		else
		begin
			unique case (state)
				afterReset: state <= startFlow;
				startFlow:
				begin
					upc   <= flowFetch;
					state <= runFlow;
				end
				runFlow:
				begin
					if (wCmd == fetch)
					begin
						ir  <= mcuRdData;
						upc <= lookupFlow(mcuRdData);
					end
					else
						upc <= upcInc;
					if (wCmd == cpuPkg::halt)
						state <= halted;
					else if (eofHit)
						state <= endFlow;
				end
				endFlow:    state <= startFlow;
				halted:     state <= halted;
				default:    state <= afterReset;
			endcase
		end
	end

	assign uop.valid  = (state == runFlow);
	assign uop.cmd    = wCmd;
	assign uop.src    = resolveSel(wSrc, ir);
	assign uop.dst    = resolveSel(wDst, ir);
	assign uop.incPc  = wInc;
	assign uop.opcode = ir;
	assign halt       = (state == halted);

endmodule

`default_nettype wire

// File: hw/uopExecute.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module uopExecute import cpuPkg::*;
(
	input  dataT mcuRdData,
	output addrT mcuAddr,
	output dataT mcuWrData,
	output logic mcuWe,
	uopIf.rcv    uop,
	regIf.drv    regs
);

	dataT srcByte;
	dataT accA;
	dataT aluRes;
	logic aluZero;
	addrT srcAddr;
	addrT dstAddr;

	// Reads go through the source select and writes through the destination select
	function automatic addrT addrOf(input regSelT sel, input addrT pcVal, input addrT hlVal,
		input addrT x16Val);
		case (sel)
			`SEL_PC:              return pcVal;
			`SEL_HL:              return hlVal;
			`SEL_X16L, `SEL_X16H: return x16Val;
			default:              return pcVal;
		endcase
	endfunction

	// --------------------
	// Operand and address selection
	// --------------------
	always_comb
	begin
		case (uop.src)
			`SEL_X8:   srcByte = regs.x8;
			`SEL_X16L: srcByte = regs.x16[7:0];
			`SEL_X16H: srcByte = regs.x16[15:8];
			default:   srcByte = regs.rdVal[uop.src[2:0]];
		endcase
	end

	assign srcAddr = addrOf(uop.src, regs.pc, regs.hl, regs.x16);
	assign dstAddr = addrOf(uop.dst, regs.pc, regs.hl, regs.x16);

	// --------------------
	// ALU
	// --------------------
	// Opcode bit 3 tells XOR from AND
	assign accA    = regs.rdVal[`REG_A];
	assign aluRes  = uop.opcode[3] ? (accA ^ srcByte) : (accA & srcByte);
	assign aluZero = (aluRes == '0);

	assign mcuWrData = srcByte;

	// --------------------
	// Command decode
	// --------------------
	always_comb
	begin
		mcuAddr        = regs.pc;
		mcuWe          = 1'b0;
		regs.writeEn   = 1'b0;
		regs.writeSel  = uop.dst;
		regs.writeData = srcByte;
		regs.flagsWe   = 1'b0;
		regs.zeroFlag  = aluZero;
		regs.pcLoad    = 1'b0;
		regs.pcInc     = uop.valid & uop.incPc;

		if (uop.valid)
		begin
			case (uop.cmd)
				fetch:
				begin
					mcuAddr = regs.pc;
				end
				sma:
				begin
					mcuAddr        = srcAddr;
					regs.writeEn   = 1'b1;
					regs.writeSel  = `SEL_X8;
					regs.writeData = mcuRdData;
				end
				srm:
				begin
					mcuAddr        = srcAddr;
					regs.writeEn   = 1'b1;
					regs.writeData = mcuRdData;
				end
				smw:
				begin
					mcuAddr = dstAddr;
					mcuWe   = 1'b1;
				end
				aluOp:
				begin
					regs.writeEn   = 1'b1;
					regs.writeData = aluRes;
					regs.flagsWe   = 1'b1;
				end
				ldrr:
				begin
					regs.writeEn = 1'b1;
				end
				spc:
				begin
					regs.pcLoad = 1'b1;
				end
				default:
				begin
					mcuWe = 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/cpuPkg.sv
hw/cpuIf.sv
hw/ucodeDecode.sv
hw/uopExecute.sv
hw/regResult.sv
hw/dzCore.sv
tests/coreChecker.sv
tests/tbCore.sv

// File: tests/coreCases.txt
# Rows: c <case id> | p <addr> <count> <bytes> | w <addr> <data> | e runs the case
# All numbers are hex and w rows list the expected memory writes in order
c 1
p 0000 0A 26 12 2E 34 06 5A 70 36 C3 76
w 1234 5A
w 1234 C3
e
c 2
p 0000 0E 0E 9D 51 5A 26 20 2E 00 73 7A 2E 01 77 76
w 2000 9D
w 2001 9D
e
c 3
p 0000 10 3E F0 06 3C A0 26 30 2E 00 77 0E 55 A9 2E 01 77
p 0010 0D AF 2E 02 77 3E FF 2E 01 AE 2E 03 77 76
w 3000 30
w 3001 65
w 3002 00
w 3003 9A
e
c 4
p 0000 0D 26 40 2E 00 7E 2E 80 77 46 2E 81 70 76
p 4000 01 C5
w 4080 C5
w 4081 C5
e
c 5
p 0000 0B 26 50 2E 00 3E 11 C3 20 00 77 76
p 0020 06 3E 22 77 C3 00 01
p 0100 04 2E 01 77 76
w 5000 22
w 5001 22
e
c 6
p 0000 07 00 26 60 00 76 77 70
e

// File: tests/coreChecker.sv
`timescale 1ns/1ps
`default_nettype none

module coreChecker import cpuPkg::*;
(
	input logic iClock,
	input logic rstN,
	input addrT mcuAddr,
	input dataT mcuWrData,
	input logic mcuWe,
	input logic halt
);

	// Expected writes in the order the program should issue them
	addrT expAddr [$];
	dataT expData [$];
	int   errorCount = 0;
	int   writeCount = 0;

	task automatic clearExpect();
		expAddr.delete();
		expData.delete();
	endtask

	task automatic addExpect(input addrT a, input dataT d);
		expAddr.push_back(a);
		expData.push_back(d);
	endtask

	// Anything still queued once the core has halted was never written
	task automatic closeCase(input int caseId);
		if (expAddr.size() != 0)
		begin
			$display("Case %0d halted with %0d expected writes missing, the first one to %h",
				caseId, expAddr.size(), expAddr[0]);
			errorCount++;
		end
	endtask

	// --------------------
	// Bus monitor
	// --------------------
	// Sampled on the rising edge, before the DUT flops and the memory update
	always @(posedge iClock)
	begin
		addrT wantAddr;
		dataT wantData;
		if (!rstN)
		begin
			if (mcuWe !== 1'b0 || halt !== 1'b0)
			begin
				$display("FAILED at %0t: in reset mcuWe=%b halt=%b, both should be 0",
					$time, mcuWe, halt);
				errorCount++;
			end
		end
		else if (mcuWe === 1'b1)
		begin
			writeCount++;
			if (halt === 1'b1)
			begin
				$display("A write to %h happened at %0t while the core was halted",
					mcuAddr, $time);
				errorCount++;
			end
			if (expAddr.size() == 0)
			begin
				$display("Unexpected extra write of %h to %h at %0t", mcuWrData, mcuAddr, $time);
				errorCount++;
			end
			else
			begin
				wantAddr = expAddr.pop_front();
				wantData = expData.pop_front();
				if (mcuAddr !== wantAddr || mcuWrData !== wantData)
				begin
					$display("FAILED at %0t: expected write %h to %h, got %h to %h",
						$time, wantData, wantAddr, mcuWrData, mcuAddr);
					errorCount++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/tbCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbCore import cpuPkg::*;
();

	localparam int haltLimit   = 2000;
	localparam int resetCycles = 5;

	logic iClock;
	logic rstN;
	addrT mcuAddr;
	dataT mcuWrData;
	logic mcuWe;
	dataT mcuRdData;
	logic halt;

	dataT mem [0:65535];

	int   failCount = 0;
	int   caseCount = 0;
	logic timedOut  = 1'b0;

	dzCore i_dut
	(
		.iClock    (iClock),
		.rstN      (rstN),
		.mcuAddr   (mcuAddr),
		.mcuWrData (mcuWrData),
		.mcuWe     (mcuWe),
		.mcuRdData (mcuRdData),
		.halt      (halt)
	);

	coreChecker uChecker
	(
		.iClock    (iClock),
		.rstN      (rstN),
		.mcuAddr   (mcuAddr),
		.mcuWrData (mcuWrData),
		.mcuWe     (mcuWe),
		.halt      (halt)
	);

	// --------------------
	// Clock and memory model
	// --------------------
	initial
	begin
		iClock = 1'b0;
		forever
			#20 iClock = ~iClock;
	end

	// Reads answer in the same cycle and writes land on the rising edge
	assign mcuRdData = mem[mcuAddr];

	always @(posedge iClock)
	begin
		if (mcuWe === 1'b1)
			mem[mcuAddr] <= mcuWrData;
	end

	// Background pattern mixes both address bytes
	task automatic fillMemory();
		for (int a = 0; a < 65536; a++)
			mem[a] <= dataT'(a[15:8] ^ a[7:0] ^ 8'h5A);
	endtask

	task automatic runCase(input int caseId);
		int cycles;
		@(negedge iClock);
		rstN = 1'b0;
		repeat (resetCycles) @(negedge iClock);
		rstN = 1'b1;
		cycles = 0;
		while (halt !== 1'b1 && cycles < haltLimit)
		begin
			@(negedge iClock);
			cycles++;
		end
		if (halt !== 1'b1)
		begin
			$display("Timeout: case %0d did not reach halt within %0d cycles", caseId, haltLimit);
			failCount++;
			timedOut = 1'b1;
		end
		else
		begin
			// A few idle cycles catch a write that slips out after halt
			repeat (3) @(negedge iClock);
			uChecker.closeCase(caseId);
		end
		caseCount++;
	endtask

	// --------------------
	// Case reader
	// --------------------
	initial
	begin
		int                 fd;
		int                 rc;
		int                 caseId;
		int                 count;
		logic [15:0]        addrVal;
		logic [15:0]        dataVal;
		logic [8*8-1:0]     tag;
		logic [8*160-1:0]   junk;
		rstN   = 1'b1;
		caseId = 0;
		fd     = $fopen("tests/coreCases.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open tests/coreCases.txt");
			failCount++;
		end
		else
		begin
			while (!timedOut && $fscanf(fd, "%s", tag) == 1)
			begin
				if (tag == "#")
					rc = $fgets(junk, fd);
				else if (tag == "c")
				begin
					rc = $fscanf(fd, "%h", caseId);
					fillMemory();
					uChecker.clearExpect();
				end
				else if (tag == "p")
				begin
					rc = $fscanf(fd, "%h %h", addrVal, count);
					for (int i = 0; i < count; i++)
					begin
						rc = $fscanf(fd, "%h", dataVal);
						mem[addrT'(addrVal + i)] <= dataVal[7:0];
					end
				end
				else if (tag == "w")
				begin
					rc = $fscanf(fd, "%h %h", addrVal, dataVal);
					uChecker.addExpect(addrVal, dataVal[7:0]);
				end
				else if (tag == "e")
					runCase(caseId);
				else
				begin
					$display("Unrecognized entry %0s in the cases file", tag);
					failCount++;
					rc = $fgets(junk, fd);
				end
			end
			$fclose(fd);
		end
		if (caseCount == 0 && failCount == 0)
		begin
			$display("The cases file held no case to run");
			failCount++;
		end
		$display("Summary: %0d cases run, %0d writes checked, %0d errors",
			caseCount, uChecker.writeCount, failCount + uChecker.errorCount);
		if (failCount + uChecker.errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
